// ==== src/pkt_params.svh ====
`ifndef PKT_PARAMS_SVH
`define PKT_PARAMS_SVH

// FIFO depth is 2**PKT_FIFO_ADDR_WIDTH beats.
`define PKT_FIFO_ADDR_WIDTH 4

`define PKT_DATA_WIDTH 32
`define PKT_KEEP_WIDTH 4
`define PKT_ID_WIDTH   4
`define PKT_DEST_WIDTH 4
`define PKT_USER_WIDTH 1

`define PKT_AXIL_ADDR_WIDTH 5 // 0x10..0x1c stay unmapped.

`define PKT_REG_CTRL 'h0
`define PKT_REG_GOOD 'h4
`define PKT_REG_BAD  'h8
`define PKT_REG_OVF  'hc

`endif

// ==== src/pkt_pkg.sv ====
`default_nettype none

`include "pkt_params.svh"

package pkt_pkg;

  // one stream beat, also the fifo memory word.
  typedef struct packed {
    logic [`PKT_DATA_WIDTH-1:0] data;
    logic [`PKT_KEEP_WIDTH-1:0] keep;
    logic                       last;
    logic [`PKT_ID_WIDTH-1:0]   id;
    logic [`PKT_DEST_WIDTH-1:0] dest;
    logic [`PKT_USER_WIDTH-1:0] user;
  } axis_beat_t;

  typedef logic [31:0] stat_cnt_t; // wraps at 2**32.

  typedef enum logic [1:0] {
    AXIL_OKAY   = 2'b00,
    AXIL_SLVERR = 2'b10
  } axil_resp_t;

endpackage

`default_nettype wire

// ==== src/pkt_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pkt_params.svh"

interface axis_if;
  logic                valid;
  logic                ready;
  pkt_pkg::axis_beat_t beat;

  modport src (output valid, output beat, input ready);
  modport dst (input valid, input beat, output ready);
endinterface

interface axil_if;
  logic [`PKT_AXIL_ADDR_WIDTH-1:0] awaddr;
  logic                            awvalid;
  logic                            awready;
  logic [31:0]                     wdata;
  logic [3:0]                      wstrb;
  logic                            wvalid;
  logic                            wready;
  pkt_pkg::axil_resp_t             bresp;
  logic                            bvalid;
  logic                            bready;
  logic [`PKT_AXIL_ADDR_WIDTH-1:0] araddr;
  logic                            arvalid;
  logic                            arready;
  logic [31:0]                     rdata;
  pkt_pkg::axil_resp_t             rresp;
  logic                            rvalid;
  logic                            rready;

  modport master (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );
  modport slave (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );
endinterface

// counter path from the statistics block to the register block.
interface frame_stat_if;
  pkt_pkg::stat_cnt_t good_cnt;
  pkt_pkg::stat_cnt_t bad_cnt;
  pkt_pkg::stat_cnt_t ovf_cnt;
  logic               clear;

  modport stats (output good_cnt, bad_cnt, ovf_cnt, input clear);
  modport regs (input good_cnt, bad_cnt, ovf_cnt, output clear);
endinterface

`default_nettype wire

// ==== src/axis_frame_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pkt_params.svh"

module axis_frame_fifo (
  input  logic clk,
  input  logic rst,
  axis_if.dst  s,
  axis_if.src  m,
  input  logic drop_bad_en,
  output logic good_frame,
  output logic bad_frame,
  output logic overflow
);

  localparam int addr_width = `PKT_FIFO_ADDR_WIDTH;
  localparam int depth = 2 ** addr_width;

  pkt_pkg::axis_beat_t mem [depth];

  logic [addr_width:0] wr_ptr;      // committed frames end here.
  logic [addr_width:0] wr_ptr_next;
  logic [addr_width:0] wr_ptr_cur;  // frame in progress.
  logic [addr_width:0] wr_ptr_cur_next;
  logic [addr_width:0] rd_ptr;
  logic [addr_width:0] rd_ptr_next;

  logic drop_frame;
  logic drop_frame_next;
  logic good_next;
  logic bad_next;
  logic ovf_next;

  logic s_hs;
  logic write;
  logic read;
  logic store_output;
  logic full_cur;
  logic empty;

  pkt_pkg::axis_beat_t mem_rd_data;
  logic                mem_rd_valid;
  logic                mem_rd_valid_next;
  pkt_pkg::axis_beat_t out_beat;
  logic                out_valid;

  assign s.ready = 1'b1; // frames that do not fit are dropped instead.
  assign s_hs = s.valid && s.ready;

  assign full_cur = (wr_ptr_cur[addr_width] != rd_ptr[addr_width]) &&
                    (wr_ptr_cur[addr_width-1:0] == rd_ptr[addr_width-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  assign m.valid = out_valid;
  assign m.beat = out_beat;

  // write side.
  always_comb begin
    write = 1'b0;
    wr_ptr_next = wr_ptr;
    wr_ptr_cur_next = wr_ptr_cur;
    drop_frame_next = drop_frame;
    good_next = 1'b0;
    bad_next = 1'b0;
    ovf_next = 1'b0;
    if (s_hs) begin
      if (full_cur || drop_frame) begin
        drop_frame_next = 1'b1; // discard the rest of this frame.
        if (s.beat.last) begin
          wr_ptr_cur_next = wr_ptr;
          drop_frame_next = 1'b0;
          ovf_next = 1'b1;
        end
      end else begin
        write = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur + 1'b1;
        if (s.beat.last) begin
          if (drop_bad_en && s.beat.user[0]) begin
            wr_ptr_cur_next = wr_ptr; // roll back.
            bad_next = 1'b1;
          end else begin
            wr_ptr_next = wr_ptr_cur + 1'b1;
            good_next = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      wr_ptr_cur <= '0;
      drop_frame <= 1'b0;
      good_frame <= 1'b0;
      bad_frame <= 1'b0;
      overflow <= 1'b0;
    end else begin
      wr_ptr <= wr_ptr_next;
      wr_ptr_cur <= wr_ptr_cur_next;
      drop_frame <= drop_frame_next;
      good_frame <= good_next;
      bad_frame <= bad_next;
      overflow <= ovf_next;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_ptr_cur[addr_width-1:0]] <= s.beat;
    end
  end

  // read side, memory stage then output register.
  always_comb begin
    store_output = m.ready || !out_valid;
    read = 1'b0;
    rd_ptr_next = rd_ptr;
    mem_rd_valid_next = mem_rd_valid;
    if (store_output || !mem_rd_valid) begin
      if (!empty) begin
        read = 1'b1;
        mem_rd_valid_next = 1'b1;
        rd_ptr_next = rd_ptr + 1'b1;
      end else begin
        mem_rd_valid_next = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      mem_rd_valid <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      rd_ptr <= rd_ptr_next;
      mem_rd_valid <= mem_rd_valid_next;
      if (store_output) begin
        out_valid <= mem_rd_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      mem_rd_data <= mem[rd_ptr[addr_width-1:0]];
    end
    if (store_output) begin
      out_beat <= mem_rd_data;
    end
  end

  // committed data never overruns unread entries.
  ptr_dist_a: assert property (@(posedge clk) disable iff (rst)
    (addr_width+1)'(wr_ptr - rd_ptr) <= depth);

  m_stable_a: assert property (@(posedge clk) disable iff (rst)
    m.valid && !m.ready |=> m.valid && $stable(m.beat));

endmodule

`default_nettype wire

// ==== src/frame_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_stats (
  input  logic       clk,
  input  logic       rst,
  input  logic       good_frame,
  input  logic       bad_frame,
  input  logic       overflow,
  frame_stat_if.stats st
);

  // clear wins over a pulse in the same cycle.
  always_ff @(posedge clk) begin
    if (rst || st.clear) begin
      st.good_cnt <= '0;
      st.bad_cnt <= '0;
      st.ovf_cnt <= '0;
    end else begin
      if (good_frame) begin
        st.good_cnt <= st.good_cnt + 1'b1;
      end
      if (bad_frame) begin
        st.bad_cnt <= st.bad_cnt + 1'b1;
      end
      if (overflow) begin
        st.ovf_cnt <= st.ovf_cnt + 1'b1;
      end
    end
  end

  // the fifo resolves a frame to exactly one outcome.
  one_pulse_a: assert property (@(posedge clk) disable iff (rst)
    $onehot0({good_frame, bad_frame, overflow}));

endmodule

`default_nettype wire

// ==== src/axil_stat_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pkt_params.svh"

module axil_stat_regs (
  input  logic       clk,
  input  logic       rst,
  axil_if.slave      bus,
  frame_stat_if.regs st,
  output logic       drop_bad_en
);

  localparam int addr_width = `PKT_AXIL_ADDR_WIDTH;
  localparam logic [addr_width-1:0] reg_ctrl = addr_width'(`PKT_REG_CTRL);
  localparam logic [addr_width-1:0] reg_good = addr_width'(`PKT_REG_GOOD);
  localparam logic [addr_width-1:0] reg_bad = addr_width'(`PKT_REG_BAD);
  localparam logic [addr_width-1:0] reg_ovf = addr_width'(`PKT_REG_OVF);

  logic aw_hs;
  logic w_hs;
  logic ar_hs;
  logic aw_done;
  logic w_done;
  logic wr_fire;
  logic [addr_width-1:0] awaddr_q;
  logic [31:0] wdata_q;
  logic [3:0] wstrb_q;
  logic [addr_width-1:0] wr_addr;
  logic [31:0] wr_data;
  logic [3:0] wr_strb;
  pkt_pkg::axil_resp_t wr_resp;
  logic [31:0] rd_data;
  pkt_pkg::axil_resp_t rd_resp;
  logic bvalid;
  logic rvalid;

  assign bus.awready = !aw_done && !bvalid;
  assign bus.wready = !w_done && !bvalid;
  assign bus.arready = !rvalid;
  assign bus.bvalid = bvalid;
  assign bus.rvalid = rvalid;

  assign aw_hs = bus.awvalid && bus.awready;
  assign w_hs = bus.wvalid && bus.wready;
  assign ar_hs = bus.arvalid && bus.arready;

  // address and data may arrive in either order.
  assign wr_fire = (aw_done || aw_hs) && (w_done || w_hs);
  assign wr_addr = aw_done ? awaddr_q : bus.awaddr;
  assign wr_data = w_done ? wdata_q : bus.wdata;
  assign wr_strb = w_done ? wstrb_q : bus.wstrb;

  always_comb begin
    case (wr_addr)
      reg_ctrl, reg_good, reg_bad, reg_ovf: wr_resp = pkt_pkg::AXIL_OKAY;
      default: wr_resp = pkt_pkg::AXIL_SLVERR;
    endcase
  end

  always_comb begin
    rd_data = '0;
    rd_resp = pkt_pkg::AXIL_OKAY;
    case (bus.araddr)
      reg_ctrl: rd_data = {31'd0, drop_bad_en}; // clear bit reads 0.
      reg_good: rd_data = st.good_cnt;
      reg_bad:  rd_data = st.bad_cnt;
      reg_ovf:  rd_data = st.ovf_cnt;
      default:  rd_resp = pkt_pkg::AXIL_SLVERR;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      aw_done <= 1'b0;
      w_done <= 1'b0;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
      drop_bad_en <= 1'b0;
      st.clear <= 1'b0;
    end else begin
      st.clear <= 1'b0;
      if (wr_fire) begin
        aw_done <= 1'b0;
        w_done <= 1'b0;
        bvalid <= 1'b1;
        if (wr_addr == reg_ctrl && wr_strb[0]) begin
          drop_bad_en <= wr_data[0];
          st.clear <= wr_data[1]; // one cycle pulse.
        end
      end else begin
        if (aw_hs) aw_done <= 1'b1;
        if (w_hs) w_done <= 1'b1;
        if (bvalid && bus.bready) bvalid <= 1'b0;
      end
      if (ar_hs) begin
        rvalid <= 1'b1;
      end else if (rvalid && bus.rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) awaddr_q <= bus.awaddr;
    if (w_hs) begin
      wdata_q <= bus.wdata;
      wstrb_q <= bus.wstrb;
    end
    if (wr_fire) bus.bresp <= wr_resp;
    if (ar_hs) begin
      bus.rdata <= rd_data;
      bus.rresp <= rd_resp;
    end
  end

  b_hold_a: assert property (@(posedge clk) disable iff (rst)
    bus.bvalid && !bus.bready |=> bus.bvalid);

  r_hold_a: assert property (@(posedge clk) disable iff (rst)
    bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata));

endmodule

`default_nettype wire

// ==== src/pkt_buffer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pkt_params.svh"

module pkt_buffer_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [`PKT_DATA_WIDTH-1:0]      s_axis_tdata,
  input  logic [`PKT_KEEP_WIDTH-1:0]      s_axis_tkeep,
  input  logic                            s_axis_tvalid,
  output logic                            s_axis_tready,
  input  logic                            s_axis_tlast,
  input  logic [`PKT_ID_WIDTH-1:0]        s_axis_tid,
  input  logic [`PKT_DEST_WIDTH-1:0]      s_axis_tdest,
  input  logic [`PKT_USER_WIDTH-1:0]      s_axis_tuser,
  output logic [`PKT_DATA_WIDTH-1:0]      m_axis_tdata,
  output logic [`PKT_KEEP_WIDTH-1:0]      m_axis_tkeep,
  output logic                            m_axis_tvalid,
  input  logic                            m_axis_tready,
  output logic                            m_axis_tlast,
  output logic [`PKT_ID_WIDTH-1:0]        m_axis_tid,
  output logic [`PKT_DEST_WIDTH-1:0]      m_axis_tdest,
  output logic [`PKT_USER_WIDTH-1:0]      m_axis_tuser,
  input  logic [`PKT_AXIL_ADDR_WIDTH-1:0] s_axil_awaddr,
  input  logic                            s_axil_awvalid,
  output logic                            s_axil_awready,
  input  logic [31:0]                     s_axil_wdata,
  input  logic [3:0]                      s_axil_wstrb,
  input  logic                            s_axil_wvalid,
  output logic                            s_axil_wready,
  output logic [1:0]                      s_axil_bresp,
  output logic                            s_axil_bvalid,
  input  logic                            s_axil_bready,
  input  logic [`PKT_AXIL_ADDR_WIDTH-1:0] s_axil_araddr,
  input  logic                            s_axil_arvalid,
  output logic                            s_axil_arready,
  output logic [31:0]                     s_axil_rdata,
  output logic [1:0]                      s_axil_rresp,
  output logic                            s_axil_rvalid,
  input  logic                            s_axil_rready
);

  axis_if       s_if ();
  axis_if       m_if ();
  axil_if       axil ();
  frame_stat_if stat ();

  logic good_frame;
  logic bad_frame;
  logic overflow;
  logic drop_bad_en;

  // stream input onto the beat struct.
  assign s_if.valid = s_axis_tvalid;
  assign s_axis_tready = s_if.ready;
  assign s_if.beat = '{data: s_axis_tdata, keep: s_axis_tkeep, last: s_axis_tlast,
                       id: s_axis_tid, dest: s_axis_tdest, user: s_axis_tuser};

  assign m_axis_tvalid = m_if.valid;
  assign m_if.ready = m_axis_tready;
  assign m_axis_tdata = m_if.beat.data;
  assign m_axis_tkeep = m_if.beat.keep;
  assign m_axis_tlast = m_if.beat.last;
  assign m_axis_tid = m_if.beat.id;
  assign m_axis_tdest = m_if.beat.dest;
  assign m_axis_tuser = m_if.beat.user;

  assign axil.awaddr = s_axil_awaddr;
  assign axil.awvalid = s_axil_awvalid;
  assign s_axil_awready = axil.awready;
  assign axil.wdata = s_axil_wdata;
  assign axil.wstrb = s_axil_wstrb;
  assign axil.wvalid = s_axil_wvalid;
  assign s_axil_wready = axil.wready;
  assign s_axil_bresp = axil.bresp;
  assign s_axil_bvalid = axil.bvalid;
  assign axil.bready = s_axil_bready;
  assign axil.araddr = s_axil_araddr;
  assign axil.arvalid = s_axil_arvalid;
  assign s_axil_arready = axil.arready;
  assign s_axil_rdata = axil.rdata;
  assign s_axil_rresp = axil.rresp;
  assign s_axil_rvalid = axil.rvalid;
  assign axil.rready = s_axil_rready;

  axis_frame_fifo u_fifo (
    .clk         (clk),
    .rst         (rst),
    .s           (s_if.dst),
    .m           (m_if.src),
    .drop_bad_en (drop_bad_en),
    .good_frame  (good_frame),
    .bad_frame   (bad_frame),
    .overflow    (overflow)
  );

  frame_stats u_stats (
    .clk        (clk),
    .rst        (rst),
    .good_frame (good_frame),
    .bad_frame  (bad_frame),
    .overflow   (overflow),
    .st         (stat.stats)
  );

  axil_stat_regs u_regs (
    .clk         (clk),
    .rst         (rst),
    .bus         (axil.slave),
    .st          (stat.regs),
    .drop_bad_en (drop_bad_en)
  );

endmodule

`default_nettype wire

// ==== tb/tb_pkt_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pkt_params.svh"

module tb_pkt_buffer;

  localparam int depth = 2 ** `PKT_FIFO_ADDR_WIDTH;
  localparam int aw = `PKT_AXIL_ADDR_WIDTH;
  localparam int wait_limit = 2000;

  logic                       clk;
  logic                       rst;
  logic [`PKT_DATA_WIDTH-1:0] s_axis_tdata;
  logic [`PKT_KEEP_WIDTH-1:0] s_axis_tkeep;
  logic                       s_axis_tvalid;
  logic                       s_axis_tready;
  logic                       s_axis_tlast;
  logic [`PKT_ID_WIDTH-1:0]   s_axis_tid;
  logic [`PKT_DEST_WIDTH-1:0] s_axis_tdest;
  logic [`PKT_USER_WIDTH-1:0] s_axis_tuser;
  logic [`PKT_DATA_WIDTH-1:0] m_axis_tdata;
  logic [`PKT_KEEP_WIDTH-1:0] m_axis_tkeep;
  logic                       m_axis_tvalid;
  logic                       m_axis_tready;
  logic                       m_axis_tlast;
  logic [`PKT_ID_WIDTH-1:0]   m_axis_tid;
  logic [`PKT_DEST_WIDTH-1:0] m_axis_tdest;
  logic [`PKT_USER_WIDTH-1:0] m_axis_tuser;
  logic [aw-1:0]              s_axil_awaddr;
  logic                       s_axil_awvalid;
  logic                       s_axil_awready;
  logic [31:0]                s_axil_wdata;
  logic [3:0]                 s_axil_wstrb;
  logic                       s_axil_wvalid;
  logic                       s_axil_wready;
  logic [1:0]                 s_axil_bresp;
  logic                       s_axil_bvalid;
  logic                       s_axil_bready;
  logic [aw-1:0]              s_axil_araddr;
  logic                       s_axil_arvalid;
  logic                       s_axil_arready;
  logic [31:0]                s_axil_rdata;
  logic [1:0]                 s_axil_rresp;
  logic                       s_axil_rvalid;
  logic                       s_axil_rready;

  integer seed;
  integer ready_seed;
  int ready_mode; // 0 low, 2 random.
  bit drop_model;
  pkt_pkg::stat_cnt_t exp_good;
  pkt_pkg::stat_cnt_t exp_bad;
  pkt_pkg::stat_cnt_t exp_ovf;
  pkt_pkg::axis_beat_t exp_q [$];
  pkt_pkg::axis_beat_t frame_buf [8];

  pkt_buffer_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("*** FAILED ***");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    stop_with_failure();
  endtask

  task automatic check_beat(input string name, input pkt_pkg::axis_beat_t exp,
                            input pkt_pkg::axis_beat_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_cnt(input string name, input pkt_pkg::stat_cnt_t exp,
                           input pkt_pkg::stat_cnt_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_resp(input string name, input pkt_pkg::axil_resp_t exp,
                            input pkt_pkg::axil_resp_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #2;
    end
  endtask

  // random fields, tuser bit 0 of the last beat marks a bad frame.
  function automatic void build_frame(input int len, input bit bad);
    for (int i = 0; i < len; i++) begin
      frame_buf[i].data = `PKT_DATA_WIDTH'($random(seed));
      frame_buf[i].keep = `PKT_KEEP_WIDTH'($random(seed));
      frame_buf[i].last = (i == len - 1);
      frame_buf[i].id = `PKT_ID_WIDTH'($random(seed));
      frame_buf[i].dest = `PKT_DEST_WIDTH'($random(seed));
      frame_buf[i].user = `PKT_USER_WIDTH'($random(seed));
    end
    frame_buf[len-1].user[0] = bad;
  endfunction

  // with m_axis_tready low the output pipeline holds two beats beyond the fifo depth.
  function automatic void predict_frame(input int len, input bit ovf_mode);
    if (ovf_mode && exp_q.size() + len > depth + 2) begin
      exp_ovf++;
    end else if (drop_model && frame_buf[len-1].user[0]) begin
      exp_bad++;
    end else begin
      exp_good++;
      for (int i = 0; i < len; i++) begin
        exp_q.push_back(frame_buf[i]);
      end
    end
  endfunction

  task automatic send_frame(input int len, input bit ovf_mode);
    int n;
    n = 0;
    while (!ovf_mode && exp_q.size() + len > depth) begin // keep normal frames fitting.
      n++;
      if (n > wait_limit) report_timeout("room in the FIFO for the next frame");
      @(posedge clk);
      #2;
    end
    predict_frame(len, ovf_mode);
    for (int i = 0; i < len; i++) begin
      s_axis_tdata = frame_buf[i].data;
      s_axis_tkeep = frame_buf[i].keep;
      s_axis_tlast = frame_buf[i].last;
      s_axis_tid = frame_buf[i].id;
      s_axis_tdest = frame_buf[i].dest;
      s_axis_tuser = frame_buf[i].user;
      s_axis_tvalid = 1'b1;
      n = 0;
      @(posedge clk);
      while (!s_axis_tready) begin
        n++;
        if (n > wait_limit) report_timeout("s_axis_tready");
        @(posedge clk);
      end
      #2;
    end
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      n++;
      if (n > wait_limit) report_timeout("the expected beats on m_axis");
      @(posedge clk);
      #2;
    end
    idle(4);
    check_bit("m_axis_tvalid", 1'b0, m_axis_tvalid);
  endtask

  task automatic axil_write(input logic [aw-1:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output pkt_pkg::axil_resp_t resp);
    bit aw_ok;
    bit w_ok;
    int n;
    s_axil_awaddr = addr;
    s_axil_wdata = data;
    s_axil_wstrb = strb;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid = 1'b1;
    s_axil_bready = 1'b1;
    aw_ok = 1'b0;
    w_ok = 1'b0;
    n = 0;
    while (!(aw_ok && w_ok)) begin
      @(posedge clk);
      if (s_axil_awvalid && s_axil_awready) aw_ok = 1'b1;
      if (s_axil_wvalid && s_axil_wready) w_ok = 1'b1;
      #2;
      if (aw_ok) s_axil_awvalid = 1'b0;
      if (w_ok) s_axil_wvalid = 1'b0;
      n++;
      if (n > 50) report_timeout("awready and wready");
    end
    n = 0;
    @(posedge clk);
    while (!s_axil_bvalid) begin
      n++;
      if (n > 50) report_timeout("bvalid");
      @(posedge clk);
    end
    resp = pkt_pkg::axil_resp_t'(s_axil_bresp);
    #2;
    s_axil_bready = 1'b0;
  endtask

  task automatic axil_read(input logic [aw-1:0] addr, output logic [31:0] data,
                           output pkt_pkg::axil_resp_t resp);
    int n;
    s_axil_araddr = addr;
    s_axil_arvalid = 1'b1;
    s_axil_rready = 1'b1;
    n = 0;
    @(posedge clk);
    while (!s_axil_arready) begin
      n++;
      if (n > 50) report_timeout("arready");
      @(posedge clk);
    end
    #2;
    s_axil_arvalid = 1'b0;
    n = 0;
    @(posedge clk);
    while (!s_axil_rvalid) begin
      n++;
      if (n > 50) report_timeout("rvalid");
      @(posedge clk);
    end
    data = s_axil_rdata;
    resp = pkt_pkg::axil_resp_t'(s_axil_rresp);
    #2;
    s_axil_rready = 1'b0;
  endtask

  task automatic write_ctrl(input logic [31:0] data);
    pkt_pkg::axil_resp_t resp;
    axil_write(`PKT_REG_CTRL, data, 4'hf, resp);
    check_resp("bresp CTRL", pkt_pkg::AXIL_OKAY, resp);
    drop_model = data[0];
    if (data[1]) begin
      exp_good = '0;
      exp_bad = '0;
      exp_ovf = '0;
    end
  endtask

  task automatic read_ctrl(input logic [31:0] exp);
    logic [31:0] value;
    pkt_pkg::axil_resp_t resp;
    axil_read(`PKT_REG_CTRL, value, resp);
    check_resp("rresp CTRL", pkt_pkg::AXIL_OKAY, resp);
    check_data("CTRL", exp, value);
  endtask

  task automatic verify_counters();
    pkt_pkg::stat_cnt_t value;
    pkt_pkg::axil_resp_t resp;
    idle(3); // pulse, then counter update.
    axil_read(`PKT_REG_GOOD, value, resp);
    check_resp("rresp GOOD", pkt_pkg::AXIL_OKAY, resp);
    check_cnt("GOOD", exp_good, value);
    axil_read(`PKT_REG_BAD, value, resp);
    check_resp("rresp BAD", pkt_pkg::AXIL_OKAY, resp);
    check_cnt("BAD", exp_bad, value);
    axil_read(`PKT_REG_OVF, value, resp);
    check_resp("rresp OVF", pkt_pkg::AXIL_OKAY, resp);
    check_cnt("OVF", exp_ovf, value);
  endtask

  initial begin : ready_drive
    forever begin
      @(posedge clk);
      #2;
      case (ready_mode)
        0: m_axis_tready = 1'b0;
        default: m_axis_tready = 1'($random(ready_seed));
      endcase
    end
  end

  // every accepted output beat must match the head of the expected queue.
  initial begin : monitor
    pkt_pkg::axis_beat_t act;
    forever begin
      @(posedge clk);
      if (!rst && m_axis_tvalid && m_axis_tready) begin
        act.data = m_axis_tdata;
        act.keep = m_axis_tkeep;
        act.last = m_axis_tlast;
        act.id = m_axis_tid;
        act.dest = m_axis_tdest;
        act.user = m_axis_tuser;
        if (exp_q.size() == 0) begin
          $display("unexpected beat %h on m_axis at %0t", act, $time);
          stop_with_failure();
        end else begin
          check_beat("m_axis beat", exp_q.pop_front(), act);
        end
      end
    end
  end

  initial begin : main
    int len;
    int frames;
    pkt_pkg::axil_resp_t resp;
    logic [31:0] rdata;
    seed = 32'hd0f5_99ff;
    ready_seed = seed ^ 32'h0000_0001;
    ready_mode = 0;
    drop_model = 1'b0;
    exp_good = '0;
    exp_bad = '0;
    exp_ovf = '0;
    rst = 1'b1;
    s_axis_tdata = '0;
    s_axis_tkeep = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
    s_axis_tid = '0;
    s_axis_tdest = '0;
    s_axis_tuser = '0;
    m_axis_tready = 1'b0;
    s_axil_awaddr = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata = '0;
    s_axil_wstrb = '0;
    s_axil_wvalid = 1'b0;
    s_axil_bready = 1'b0;
    s_axil_araddr = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;

    idle(2);
    check_bit("m_axis_tvalid", 1'b0, m_axis_tvalid);
    check_bit("s_axis_tready", 1'b1, s_axis_tready);
    verify_counters();
    read_ctrl(32'h0);

    ready_mode = 2; // good frames under random back-pressure.
    repeat (24) begin
      len = 1 + {$random(seed)} % 8;
      build_frame(len, 1'b0);
      send_frame(len, 1'b0);
      idle({$random(seed)} % 3);
    end
    drain();
    verify_counters();

    write_ctrl(32'h1);
    read_ctrl(32'h1);
    repeat (12) begin
      len = 1 + {$random(seed)} % 8;
      build_frame(len, 1'($random(seed)));
      send_frame(len, 1'b0);
    end
    drain();
    verify_counters();
    write_ctrl(32'h0); // bad-marked frames now pass.
    read_ctrl(32'h0);
    repeat (6) begin
      len = 1 + {$random(seed)} % 8;
      build_frame(len, 1'b1);
      send_frame(len, 1'b0);
    end
    drain();
    verify_counters();

    ready_mode = 0;
    idle(2);
    frames = 0;
    while (exp_ovf < 2) begin
      frames++;
      if (frames > 40) begin
        $display("no frame overflowed the FIFO after %0d frames", frames - 1);
        stop_with_failure();
      end
      len = 1 + {$random(seed)} % 8;
      build_frame(len, 1'b0);
      send_frame(len, 1'b1);
      idle(4);
    end
    verify_counters();
    ready_mode = 2;
    drain();
    verify_counters();

    write_ctrl(32'h3);
    read_ctrl(32'h1);
    verify_counters();
    write_ctrl(32'h0);
    axil_write(5'h10, 32'hffff_ffff, 4'hf, resp);
    check_resp("bresp 0x10", pkt_pkg::AXIL_SLVERR, resp);
    read_ctrl(32'h0);
    axil_read(5'h10, rdata, resp);
    check_resp("rresp 0x10", pkt_pkg::AXIL_SLVERR, resp);
    check_data("rdata 0x10", 32'h0, rdata);
    verify_counters();

    idle(4);
    check_bit("m_axis_tvalid", 1'b0, m_axis_tvalid);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+src
src/pkt_pkg.sv
src/pkt_ifs.sv
src/axis_frame_fifo.sv
src/frame_stats.sv
src/axil_stat_regs.sv
src/pkt_buffer_top.sv
tb/tb_pkt_buffer.sv
